// File: flist.f
+incdir+include
verilog/nice_pkg.sv
verilog/string_assembler.sv
verilog/repeat_gap_detector.sv
verilog/non_overlapping_pairs_tracker.sv
verilog/nice_tally.sv
verilog/nice_string_filter_top.sv
bench/tb_clock_gen.sv
bench/nice_chk.sv
bench/nice_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the nice string filter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module nice_tb -f flist.f -o nice_sim

./obj_dir/nice_sim | tee sim.log

if grep -q "^Test passed$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: bench/nice_patterns.txt
# columns: string, class
# class N is nice, X is naughty, E is rejected (length not 16 or a char outside a..z)
qjhvhtzxzqqjkmpb N
xxyxxbcdefghijkl N
uurcxstgmygtbstg X
ieodomkazucvgmuy X
aaabcdefghijklmn X
aaaabcdefghijklm N
abcabc E
xyxybcdefghijklm N
abcdefghabmnopqr X
abcdefghijklmnop X
abcdcfghijklmnab N
qjhvhtzxzqqjkmpbq E
zyabcdefghijzyxy N
qjhvhtzxz1qjkmpb E
aaaaaaaaaaaaaaaa N
qjhvhtZxzqqjkmpb E
abababababababab N
a E
aabcdefgaahijklm X
mnopqrstuvwxyzyx X
qjhvhtzxzqqjkmp E
rstpqpquvwxyzabc N
abcdefghijklmno{ E
`bcdefghijklmnop E
ugknbfddgicrmopn X
aabbaabbccddeeff X
hgfedcbahgxzxabc N
abcdefgabcdefgxx X

// File: bench/nice_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nice_cfg.svh"

module nice_tb;

    typedef logic [`NICE_COUNT_BITS-1:0] count_t;

    localparam int MAX_TESTS     = 64;
    localparam int PULSE_DELAY   = 5;   // char_last cycle to nice_pulse
    localparam int COUNT_DELAY   = 2;   // char_last cycle to string/error count
    localparam int WINDOW        = 8;
    localparam int RESET_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 200;

    wire                        clk;
    wire                        arst_n;
    logic                       char_valid;
    logic [7:0]                 char_byte;
    logic                       char_last;
    wire                        nice_pulse;
    wire [`NICE_COUNT_BITS-1:0] nice_count;
    wire [`NICE_COUNT_BITS-1:0] string_count;
    wire [`NICE_COUNT_BITS-1:0] error_count;

    string      pat_str [MAX_TESTS];
    logic [7:0] pat_cls [MAX_TESTS];  // N, X or E
    int         n_pats = 0;

    int     t_end      [MAX_TESTS];   // negedge index of the char_last cycle
    count_t exp_nice   [MAX_TESTS];
    count_t exp_total  [MAX_TESTS];
    count_t exp_err    [MAX_TESTS];
    count_t snap_nice  [MAX_TESTS];
    count_t snap_total [MAX_TESTS];
    count_t snap_err   [MAX_TESTS];
    int     n_sent     = 0;
    int     next_eval  = 0;
    int     ncyc       = 0;
    int     pulse_q [$];              // negedge indices of nice_pulse
    int     pass_cnt   = 0;
    int     fail_cnt   = 0;
    int     check_errs = 0;
    bit     aborted    = 1'b0;
    integer seed;

    tb_clock_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    nice_string_filter_top uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .char_valid   (char_valid),
        .char_byte    (char_byte),
        .char_last    (char_last),
        .nice_pulse   (nice_pulse),
        .nice_count   (nice_count),
        .string_count (string_count),
        .error_count  (error_count)
    );

    task automatic judge_test(input int id);
        string name;
        int    hits;
        int    first_hit;
        int    exp_hits;
        bit    bad;
        name      = $sformatf("%0d_%s", id, pat_str[id]);
        hits      = 0;
        first_hit = -1;
        bad       = 1'b0;
        exp_hits  = (pat_cls[id] == "N") ? 1 : 0;
        while (pulse_q.size() > 0 && pulse_q[0] <= t_end[id]) begin
            $display("nice_pulse came at cycle %0d outside any string's window", pulse_q[0]);
            void'(pulse_q.pop_front());
            bad = 1'b1;
        end
        while (pulse_q.size() > 0 && pulse_q[0] <= t_end[id] + WINDOW) begin
            if (first_hit < 0) begin
                first_hit = pulse_q[0] - t_end[id];
            end
            hits++;
            void'(pulse_q.pop_front());
        end
        if (hits != exp_hits) begin
            $display("CHECK FAILED %s nice pulses expected %0d actual %0d", name, exp_hits, hits);
            bad = 1'b1;
        end
        if (hits == 1 && exp_hits == 1 && first_hit != PULSE_DELAY) begin
            $display("CHECK FAILED %s pulse delay expected %0d actual %0d",
                     name, PULSE_DELAY, first_hit);
            bad = 1'b1;
        end
        if (snap_total[id] !== exp_total[id]) begin
            $display("CHECK FAILED %s string_count expected %0d actual %0d",
                     name, exp_total[id], snap_total[id]);
            bad = 1'b1;
        end
        if (snap_err[id] !== exp_err[id]) begin
            $display("CHECK FAILED %s error_count expected %0d actual %0d",
                     name, exp_err[id], snap_err[id]);
            bad = 1'b1;
        end
        if (snap_nice[id] !== exp_nice[id]) begin
            $display("CHECK FAILED %s nice_count expected %0d actual %0d",
                     name, exp_nice[id], snap_nice[id]);
            bad = 1'b1;
        end
        if (bad) begin
            fail_cnt++;
            $display("FAIL %s class %c", name, pat_cls[id]);
        end else begin
            pass_cnt++;
            $display("ok   %s class %c", name, pat_cls[id]);
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        ncyc = ncyc + 1;
        if (nice_pulse) begin
            pulse_q.push_back(ncyc);
        end
        for (int k = next_eval; k < n_sent; k++) begin
            if (ncyc == t_end[k] + COUNT_DELAY) begin
                snap_total[k] = string_count;
                snap_err[k]   = error_count;
            end
            if (ncyc == t_end[k] + PULSE_DELAY + 1) begin
                snap_nice[k] = nice_count;  // one cycle after the pulse
            end
        end
        if (next_eval < n_sent && ncyc == t_end[next_eval] + WINDOW) begin
            judge_test(next_eval);
            next_eval = next_eval + 1;
        end
    end

    initial begin
        int     fd;
        int     got;
        int     gap;
        int     wait_cnt;
        string  line;
        string  word;
        string  cls;
        count_t run_nice;
        count_t run_total;
        count_t run_err;
        char_valid = 1'b0;
        char_byte  = 8'h00;
        char_last  = 1'b0;
        seed       = 32'haf61_34a9;
        run_nice   = '0;
        run_total  = '0;
        run_err    = '0;

        fd = $fopen("bench/nice_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/nice_patterns.txt");
            aborted = 1'b1;
        end else begin
            got = 1;
            while (got != 0 && n_pats < MAX_TESTS) begin
                got = $fgets(line, fd);
                if (got != 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %s", word, cls) == 2) begin
                        if (cls != "N" && cls != "X" && cls != "E") begin
                            $display("pattern %s has an unknown class %s", word, cls);
                            aborted = 1'b1;
                        end
                        pat_str[n_pats] = word;
                        pat_cls[n_pats] = cls.getc(0);
                        n_pats++;
                    end
                end
            end
            $fclose(fd);
        end

        wait_cnt = 0;
        while (arst_n !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            aborted = 1'b1;
        end

        if (!aborted) begin
            for (int p = 0; p < n_pats; p++) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) begin
                    @(posedge clk);
                    char_valid <= 1'b0;
                    char_last  <= 1'b0;
                end
                for (int i = 0; i < pat_str[p].len(); i++) begin
                    @(posedge clk);
                    char_valid <= 1'b1;
                    char_byte  <= pat_str[p].getc(i);
                    char_last  <= (i == pat_str[p].len() - 1);
                end
                case (pat_cls[p])
                    "N": begin
                        run_nice  = run_nice + count_t'(1);
                        run_total = run_total + count_t'(1);
                    end
                    "X": run_total = run_total + count_t'(1);
                    default: run_err = run_err + count_t'(1);
                endcase
                exp_nice[p]  = run_nice;
                exp_total[p] = run_total;
                exp_err[p]   = run_err;
                t_end[p]     = ncyc + 1;  // next negedge sees char_last
                n_sent       = p + 1;
            end
            @(posedge clk);
            char_valid <= 1'b0;
            char_last  <= 1'b0;

            wait_cnt = 0;
            while (next_eval < n_sent && wait_cnt < DRAIN_TIMEOUT) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (next_eval < n_sent) begin
                $display("timed out with %0d strings still unjudged", n_sent - next_eval);
                aborted = 1'b1;
            end
            @(negedge clk);
            if (nice_count !== run_nice) begin
                $display("CHECK FAILED final_counts nice_count expected %0d actual %0d",
                         run_nice, nice_count);
                check_errs++;
            end
            if (string_count !== run_total) begin
                $display("CHECK FAILED final_counts string_count expected %0d actual %0d",
                         run_total, string_count);
                check_errs++;
            end
            if (error_count !== run_err) begin
                $display("CHECK FAILED final_counts error_count expected %0d actual %0d",
                         run_err, error_count);
                check_errs++;
            end
            @(posedge clk);
            if (pulse_q.size() != 0) begin
                $display("nice_pulse came after the last string's window");
                check_errs++;
            end
        end

        if (uut.u_chk.assert_fails != 0) begin
            $display("bound assertions failed %0d times", uut.u_chk.assert_fails);
            check_errs++;
        end

        $display("summary: %0d tests, %0d ok, %0d failed, %0d final check errors",
                 n_sent, pass_cnt, fail_cnt, check_errs);
        if (!aborted && n_sent > 0 && fail_cnt == 0 && check_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/nice_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "nice_cfg.svh"

module nice_chk (
    input wire                        clk,
    input wire                        arst_n,
    input wire                        string_valid,
    input wire                        string_error,
    input wire                        nice_pulse,
    input wire [`NICE_COUNT_BITS-1:0] nice_count,
    input wire [`NICE_COUNT_BITS-1:0] string_count,
    input wire [`NICE_COUNT_BITS-1:0] error_count
);

    int assert_fails = 0;

    // a string is either accepted or rejected
    a_valid_or_error: assert property (
        @(posedge clk) disable iff (!arst_n) !(string_valid && string_error)
    ) else begin
        $error("string_valid and string_error high in the same cycle");
        assert_fails++;
    end

    // good strings are 16 cycles apart at least
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) nice_pulse |=> !nice_pulse
    ) else begin
        $error("nice_pulse high for two cycles in a row");
        assert_fails++;
    end

    a_nice_count_up: assert property (
        @(posedge clk) disable iff (!arst_n) nice_count >= $past(nice_count)
    ) else begin
        $error("nice_count went down");
        assert_fails++;
    end

    a_string_count_up: assert property (
        @(posedge clk) disable iff (!arst_n) string_count >= $past(string_count)
    ) else begin
        $error("string_count went down");
        assert_fails++;
    end

    a_error_count_up: assert property (
        @(posedge clk) disable iff (!arst_n) error_count >= $past(error_count)
    ) else begin
        $error("error_count went down");
        assert_fails++;
    end

endmodule

bind nice_string_filter_top nice_chk u_chk (
    .clk          (clk),
    .arst_n       (arst_n),
    .string_valid (string_valid),
    .string_error (string_error),
    .nice_pulse   (nice_pulse),
    .nice_count   (nice_count),
    .string_count (string_count),
    .error_count  (error_count)
);

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD = 5; // 10 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/nice_string_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "nice_cfg.svh"

module nice_string_filter_top (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         char_valid,
    input  wire  [7:0]                  char_byte,
    input  wire                         char_last,
    output logic                        nice_pulse,
    output logic [`NICE_COUNT_BITS-1:0] nice_count,
    output logic [`NICE_COUNT_BITS-1:0] string_count,
    output logic [`NICE_COUNT_BITS-1:0] error_count
);

    import nice_pkg::*;

    logic         string_valid;
    logic         string_error;
    logic         has_repeating_char;
    string_word_u string_word;

    string_assembler u_assembler (
        .clk          (clk),
        .arst_n       (arst_n),
        .char_valid   (char_valid),
        .char_byte    (char_byte),
        .char_last    (char_last),
        .string_valid (string_valid),
        .string_error (string_error),
        .string_word  (string_word)
    );

    // combinational, lines up with string_valid
    repeat_gap_detector u_gap (
        .string_word        (string_word),
        .has_repeating_char (has_repeating_char)
    );

    non_overlapping_pairs_tracker #(
        .STRING_DATA_WIDTH (`NICE_STR_BITS)
    ) u_pairs (
        .clk                (clk),
        .arst_n             (arst_n),
        .has_repeating_char (has_repeating_char),
        .string_valid       (string_valid),
        .string_data        (string_word.flat),
        .string_is_nice     (nice_pulse)
    );

    nice_tally u_tally (
        .clk            (clk),
        .arst_n         (arst_n),
        .string_valid   (string_valid),
        .string_error   (string_error),
        .string_is_nice (nice_pulse),
        .nice_count     (nice_count),
        .string_count   (string_count),
        .error_count    (error_count)
    );

endmodule

`default_nettype wire

// File: verilog/nice_tally.sv
`timescale 1ns/1ps
`default_nettype none

`include "nice_cfg.svh"

module nice_tally (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         string_valid,
    input  wire                         string_error,
    input  wire                         string_is_nice,
    output logic [`NICE_COUNT_BITS-1:0] nice_count,
    output logic [`NICE_COUNT_BITS-1:0] string_count,
    output logic [`NICE_COUNT_BITS-1:0] error_count
);

    // holds at all ones
    function automatic logic [`NICE_COUNT_BITS-1:0] sat_inc(
        input logic [`NICE_COUNT_BITS-1:0] value,
        input logic                         hit
    );
        logic [`NICE_COUNT_BITS-1:0] result;
        result = value;
        if (hit && (value != '1)) begin
            result = value + `NICE_COUNT_BITS'(1);
        end
        return result;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            nice_count   <= '0;
            string_count <= '0;
            error_count  <= '0;
        end else begin
            nice_count   <= sat_inc(nice_count, string_is_nice);
            string_count <= sat_inc(string_count, string_valid);  // accepted only
            error_count  <= sat_inc(error_count, string_error);
        end
    end

endmodule

`default_nettype wire

// File: verilog/non_overlapping_pairs_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "nice_cfg.svh"

module non_overlapping_pairs_tracker #(
    parameter int STRING_DATA_WIDTH = `NICE_STR_BITS
)(
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         has_repeating_char,
    input  wire                         string_valid,
    input  wire [STRING_DATA_WIDTH-1:0] string_data,
    output logic                        string_is_nice  // one cycle pulse
);

    localparam int BITS_PER_CHAR = `NICE_CHAR_BITS;
    localparam int NUM_CHARS = STRING_DATA_WIDTH / BITS_PER_CHAR;
    localparam int MIN_OFFSET = 2;  // smaller offsets would overlap
    localparam int CORRELATION_INSTANCES = NUM_CHARS - MIN_OFFSET - 1;
    localparam int FF_STAGES = 2;

    logic [FF_STAGES-1:0]             valid_shift;
    logic [CORRELATION_INSTANCES-1:0] pair_found;

    // qualifier follows the compare pipeline
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_shift <= '0;
        end else begin
            valid_shift <= {valid_shift[FF_STAGES-2:0], string_valid && has_repeating_char};
        end
    end

    genvar i;
    generate
        for (i = 0; i < CORRELATION_INSTANCES; i++) begin : correlation_blocks
            localparam int OFFSET_BITS = BITS_PER_CHAR * (i + MIN_OFFSET);
            localparam int CORR_CHARS = NUM_CHARS - (i + MIN_OFFSET);
            localparam int CORR_BITS = CORR_CHARS * BITS_PER_CHAR;

            logic [CORR_BITS-1:0]  upper_part;
            logic [CORR_BITS-1:0]  lower_part;
            logic [CORR_CHARS-1:0] char_match;
            logic [CORR_CHARS-2:0] neighbor_match;
            logic                  found_r;

            assign upper_part = string_data[STRING_DATA_WIDTH-1:OFFSET_BITS];
            assign lower_part = string_data[CORR_BITS-1:0];

            always_ff @(posedge clk) begin
                for (int j = 0; j < CORR_CHARS; j++) begin
                    char_match[j] <= (upper_part[j*BITS_PER_CHAR +: BITS_PER_CHAR] ==
                                      lower_part[j*BITS_PER_CHAR +: BITS_PER_CHAR]);
                end
            end

            // two adjacent hits form a recurring pair
            always_ff @(posedge clk) begin
                neighbor_match <= char_match[CORR_CHARS-1:1] & char_match[CORR_CHARS-2:0];
            end

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    found_r <= 1'b0;
                end else begin
                    found_r <= valid_shift[FF_STAGES-1] && (|neighbor_match);
                end
            end

            assign pair_found[i] = found_r;
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            string_is_nice <= 1'b0;
        end else begin
            string_is_nice <= |pair_found;
        end
    end

endmodule

`default_nettype wire

// File: verilog/repeat_gap_detector.sv
`timescale 1ns/1ps
`default_nettype none

`include "nice_cfg.svh"

module repeat_gap_detector (
    input  wire nice_pkg::string_word_u string_word,
    output logic                        has_repeating_char
);

    localparam int GAP = 2; // letter, one between, same letter

    // e.g. "xyx" or "aaa"
    always_comb begin
        has_repeating_char = 1'b0;
        for (int i = 0; i < `NICE_STR_CHARS - GAP; i++) begin
            if (string_word.chars[i] == string_word.chars[i+GAP]) begin
                has_repeating_char = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/string_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "nice_cfg.svh"

module string_assembler (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     char_valid,
    input  wire  [7:0]              char_byte,
    input  wire                     char_last,
    output logic                    string_valid,
    output logic                    string_error,
    output nice_pkg::string_word_u  string_word
);

    import nice_pkg::*;

    localparam int IDX_BITS = $clog2(`NICE_STR_CHARS);
    localparam int CNT_BITS = IDX_BITS + 1;
    localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(`NICE_STR_CHARS);
    localparam logic [CNT_BITS-1:0] LAST_IDX = CNT_BITS'(`NICE_STR_CHARS - 1);

    logic [CNT_BITS-1:0] char_idx;   // letters taken so far, stops at 16
    logic                bad_seen;   // sticky, cleared per string
    logic                bad_next;
    logic                is_letter;
    logic                full;
    logic                str_done;
    logic                str_ok;
    char_code_t          code;
    string_word_u        work_word;
    string_word_u        work_next;

    assign is_letter = (char_byte >= 8'h61) && (char_byte <= 8'h7a);
    assign code      = char_code_t'(char_byte - 8'h61);
    assign full      = (char_idx == FULL_CNT);
    assign bad_next  = bad_seen || !is_letter;
    assign str_done  = char_valid && char_last;

    // length is right only if this char lands on the last slot
    assign str_ok    = !bad_next && (char_idx == LAST_IDX);

    // working copy with the current char merged in
    always_comb begin
        work_next = work_word;
        if (is_letter && !full) begin
            work_next.chars[char_idx[IDX_BITS-1:0]] = code;
        end
    end

    always_ff @(posedge clk) begin
        if (char_valid) begin
            work_word <= work_next;
        end
    end

    // output word only moves when a good string completes
    always_ff @(posedge clk) begin
        if (str_done && str_ok) begin
            string_word <= work_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            char_idx     <= '0;
            bad_seen     <= 1'b0;
            string_valid <= 1'b0;
            string_error <= 1'b0;
        end else begin
            string_valid <= str_done && str_ok;
            string_error <= str_done && !str_ok;
            if (char_valid) begin
                if (char_last) begin
                    char_idx <= '0;
                    bad_seen <= 1'b0;
                end else begin
                    if (!full) begin
                        char_idx <= char_idx + CNT_BITS'(1);
                    end
                    bad_seen <= bad_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/nice_pkg.sv
`default_nettype none

`include "nice_cfg.svh"

package nice_pkg;

    // a=0 .. z=25
    typedef logic [`NICE_CHAR_BITS-1:0] char_code_t;

    // flat view for the pair tracker, letter view for the rest
    // chars[0] is the first letter received and sits in the low bits
    typedef union packed {
        logic [`NICE_STR_BITS-1:0]           flat;
        char_code_t [`NICE_STR_CHARS-1:0]    chars;
    } string_word_u;

endpackage

`default_nettype wire

// File: include/nice_cfg.svh
`ifndef NICE_CFG_SVH
`define NICE_CFG_SVH

// letters per string
`define NICE_STR_CHARS 16

`define NICE_CHAR_BITS 5 // a..z fits in 5 bits

// width of each tally counter
`define NICE_COUNT_BITS 16

`define NICE_STR_BITS (`NICE_STR_CHARS * `NICE_CHAR_BITS)

`endif
